// ==== logic/udp_sram_pkg.sv ====
// udp sram bridge package
// shared widths, command magics, listen port and beat counts
// for the udp to sram command bridge of the cnn accelerator
`default_nettype none

package udp_sram_pkg;

    typedef logic [31:0]  udp_word_t;
    typedef logic [15:0]  udp_port_t;
    typedef logic [31:0]  ip_addr_t;
    typedef logic [127:0] sram_wdata_t;
    typedef logic [511:0] sram_line_t;
    typedef logic [7:0]   sram_addr_t;

    // one inbound word, seen as a header magic or as a write address word
    typedef union packed {
        udp_word_t magic;
        struct packed {
            logic [23:0] pad;
            sram_addr_t  addr;
        } addr_view;
    } cmd_word_u;

    localparam udp_port_t LISTEN_PORT = 16'd1800;

    // command magics, write magic also opens every read-data frame
    localparam udp_word_t MAGIC_WRITE  = 32'h722acce7;
    localparam udp_word_t MAGIC_READ   = 32'h2e2acce7;
    localparam udp_word_t MAGIC_START  = 32'h5a2acce7;
    localparam udp_word_t MAGIC_FINISH = 32'haa2acce7;

    // words per sram write word and per sram read line
    localparam int WDATA_BEATS = 4;
    localparam int LINE_BEATS  = 16;

    // cycles from read enable to a valid line
    localparam int READ_LATENCY = 2;

endpackage

`default_nettype wire

// ==== logic/udp_cmd_if.sv ====
// decoded command channel
// carries command strobes and write body words from the
// inbound decoder to the sram access stage
`timescale 1ns/10ps
`default_nettype none

interface udp_cmd_if;

    logic                    cmd_write;
    logic                    cmd_read;
    logic                    body_valid;
    udp_sram_pkg::cmd_word_u body_word;
    logic                    body_end;

    modport decoder (
        output cmd_write,
        output cmd_read,
        output body_valid,
        output body_word,
        output body_end
    );

    modport executor (
        input cmd_write,
        input cmd_read,
        input body_valid,
        input body_word,
        input body_end
    );

endinterface

`default_nettype wire

// ==== logic/udp_cmd_decode.sv ====
// inbound udp command decoder
// filters frames on the listen port, classifies the header magic,
// pulses the accelerator start and forwards write body words
`timescale 1ns/10ps
`default_nettype none

module udp_cmd_decode (
    input  wire                     clk_i,
    input  wire                     reset_n_i,
    input  udp_sram_pkg::udp_word_t udp_rx_data_i,
    input  wire                     udp_rx_valid_i,
    input  wire                     udp_rx_sof_i,
    input  wire                     udp_rx_eof_i,
    input  udp_sram_pkg::udp_port_t udp_rx_src_port_i,
    input  udp_sram_pkg::udp_port_t udp_rx_dest_port_i,
    input  udp_sram_pkg::ip_addr_t  udp_rx_src_addr_i,
    output logic                    cnna_start_o,
    output udp_sram_pkg::udp_port_t this_port_o,
    output udp_sram_pkg::udp_port_t partner_port_o,
    output udp_sram_pkg::ip_addr_t  partner_addr_o,
    udp_cmd_if.decoder              cmd
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_BODY
    } state_t;

    state_t                  state_q;
    udp_sram_pkg::cmd_word_u rx_word;
    logic                    port_ok;
    logic                    in_header;
    logic                    in_body;
    logic                    hdr_valid;

    assign rx_word = udp_rx_data_i;
    assign port_ok = (udp_rx_dest_port_i == udp_sram_pkg::LISTEN_PORT);

    // a sof restarts the frame from any state
    assign in_header = udp_rx_sof_i ? port_ok : (state_q == ST_HEADER);
    assign in_body   = !udp_rx_sof_i && (state_q == ST_BODY);
    assign hdr_valid = udp_rx_valid_i && in_header;

    assign cmd.cmd_write  = hdr_valid && (rx_word.magic == udp_sram_pkg::MAGIC_WRITE);
    assign cmd.cmd_read   = hdr_valid && (rx_word.magic == udp_sram_pkg::MAGIC_READ);
    assign cmd.body_valid = udp_rx_valid_i && in_body;
    assign cmd.body_word  = rx_word;
    assign cmd.body_end   = udp_rx_eof_i && in_body;

    always_ff @(posedge clk_i or posedge reset_n_i) begin
        if (reset_n_i) begin
            state_q      <= ST_IDLE;
            cnna_start_o <= 1'b0;
        end else begin
            cnna_start_o <= hdr_valid && (rx_word.magic == udp_sram_pkg::MAGIC_START);
            if (udp_rx_eof_i) begin
                state_q <= ST_IDLE;
            end else if (hdr_valid) begin
                // only a write command carries a body
                state_q <= cmd.cmd_write ? ST_BODY : ST_IDLE;
            end else if (udp_rx_sof_i) begin
                state_q <= port_ok ? ST_HEADER : ST_IDLE;
            end
        end
    end

    // sender info of the last accepted frame
    always_ff @(posedge clk_i) begin
        if (udp_rx_sof_i && port_ok) begin
            this_port_o    <= udp_rx_dest_port_i;
            partner_port_o <= udp_rx_src_port_i;
            partner_addr_o <= udp_rx_src_addr_i;
        end
    end

    a_cmd_onehot: assert property (
        @(posedge clk_i) disable iff (reset_n_i)
        $onehot0({cmd.cmd_write, cmd.cmd_read, cmd.body_valid})
    ) else $error("command strobes and body word overlap");

endmodule

`default_nettype wire

// ==== logic/sram_access.sv ====
// sram access stage
// assembles write words from body words, runs the read pointer
// and line fetch, and multiplexes the shared sram address bus
`timescale 1ns/10ps
`default_nettype none

module sram_access (
    input  wire                       clk_i,
    input  wire                       reset_n_i,
    input  udp_sram_pkg::sram_line_t  mem_rdata_i,
    input  wire                       line_take_i,
    output udp_sram_pkg::sram_wdata_t mem_wdata_o,
    output logic                      mem_wr_en_o,
    output logic                      mem_rd_en_o,
    output udp_sram_pkg::sram_addr_t  mem_addr_o,
    output udp_sram_pkg::sram_line_t  line_o,
    output logic                      line_valid_o,
    udp_cmd_if.executor               cmd
);

    logic [2:0]                beat_q;
    udp_sram_pkg::sram_wdata_t wdata_q;
    udp_sram_pkg::sram_addr_t  wr_addr_q;
    udp_sram_pkg::sram_addr_t  rd_ptr_q;
    logic [1:0]                lat_q;
    logic                      body_data;
    logic                      body_addr;
    logic                      rd_issue;
    logic                      line_cap;

    // first four body words are data, the fifth is the address
    assign body_data = cmd.body_valid && (beat_q < 3'(udp_sram_pkg::WDATA_BEATS));
    assign body_addr = cmd.body_valid && (beat_q == 3'(udp_sram_pkg::WDATA_BEATS));

    // no new fetch while one is in flight or a line is still held
    assign rd_issue = cmd.cmd_read && !line_valid_o && (lat_q == 2'd0);
    assign line_cap = (lat_q == 2'd1);

    always_ff @(posedge clk_i or posedge reset_n_i) begin
        if (reset_n_i) begin
            beat_q       <= 3'd0;
            mem_wr_en_o  <= 1'b0;
            mem_rd_en_o  <= 1'b0;
            rd_ptr_q     <= '0;
            lat_q        <= 2'd0;
            line_valid_o <= 1'b0;
        end else begin
            mem_wr_en_o <= body_addr;
            mem_rd_en_o <= rd_issue;

            // count saturates one past the address word until eof
            if (cmd.body_end || cmd.cmd_write) begin
                beat_q <= 3'd0;
            end else if (body_data || body_addr) begin
                beat_q <= beat_q + 3'd1;
            end

            if (rd_issue) begin
                lat_q <= 2'(udp_sram_pkg::READ_LATENCY);
            end else if (lat_q != 2'd0) begin
                lat_q <= lat_q - 2'd1;
            end

            if (line_cap) begin
                line_valid_o <= 1'b1;
            end else if (line_take_i) begin
                line_valid_o <= 1'b0;
            end

            // a write command restarts reading from line zero
            if (cmd.cmd_write) begin
                rd_ptr_q <= '0;
            end else if (mem_rd_en_o) begin
                rd_ptr_q <= rd_ptr_q + 8'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (body_data) begin
            // shift in, first word ends up most significant
            wdata_q <= udp_sram_pkg::sram_wdata_t'({wdata_q, cmd.body_word.magic});
        end
        if (body_addr) begin
            wr_addr_q <= cmd.body_word.addr_view.addr;
        end
        if (line_cap) begin
            line_o <= mem_rdata_i;
        end
    end

    assign mem_wdata_o = wdata_q;
    assign mem_addr_o  = mem_rd_en_o ? rd_ptr_q : wr_addr_q;

    a_no_wr_rd: assert property (
        @(posedge clk_i) disable iff (reset_n_i)
        !(mem_wr_en_o && mem_rd_en_o)
    ) else $error("sram write and read enable high together");

endmodule

`default_nettype wire

// ==== logic/udp_tx_framer.sv ====
// outbound udp frame sequencer
// sends read lines as seventeen word frames and accelerator
// finish reports as two word frames, paced by the ready input
`timescale 1ns/10ps
`default_nettype none

module udp_tx_framer (
    input  wire                      clk_i,
    input  wire                      reset_n_i,
    input  udp_sram_pkg::sram_line_t line_i,
    input  wire                      line_valid_i,
    input  wire                      cnna_finish_i,
    input  udp_sram_pkg::udp_word_t  cnna_cycles_i,
    input  udp_sram_pkg::udp_port_t  this_port_i,
    input  udp_sram_pkg::udp_port_t  partner_port_i,
    input  udp_sram_pkg::ip_addr_t   partner_addr_i,
    input  wire                      udp_tx_ready_i,
    output logic                     line_take_o,
    output udp_sram_pkg::udp_word_t  udp_tx_data_o,
    output logic                     udp_tx_valid_o,
    output logic                     udp_tx_sof_o,
    output logic                     udp_tx_eof_o,
    output udp_sram_pkg::udp_port_t  udp_tx_src_port_o,
    output udp_sram_pkg::udp_port_t  udp_tx_dest_port_o,
    output udp_sram_pkg::ip_addr_t   udp_tx_dest_addr_o
);

    logic                     fin_pend_q;
    udp_sram_pkg::udp_word_t  fin_cycles_q;
    udp_sram_pkg::sram_line_t shift_q;
    udp_sram_pkg::udp_word_t  shift_top;
    logic [4:0]               left_q;
    logic                     start_fin;
    logic                     xfer;

    assign shift_top = shift_q[$bits(shift_q)-1 -: $bits(shift_top)];

    // a pending finish report goes before a waiting line
    assign start_fin   = !udp_tx_valid_o && fin_pend_q;
    assign line_take_o = !udp_tx_valid_o && !fin_pend_q && line_valid_i;
    assign xfer        = udp_tx_valid_o && udp_tx_ready_i;

    always_ff @(posedge clk_i or posedge reset_n_i) begin
        if (reset_n_i) begin
            fin_pend_q     <= 1'b0;
            left_q         <= 5'd0;
            udp_tx_valid_o <= 1'b0;
            udp_tx_sof_o   <= 1'b0;
            udp_tx_eof_o   <= 1'b0;
        end else begin
            if (start_fin) begin
                fin_pend_q <= 1'b0;
            end
            if (cnna_finish_i) begin
                fin_pend_q <= 1'b1;
            end

            if (start_fin || line_take_o) begin
                udp_tx_valid_o <= 1'b1;
                udp_tx_sof_o   <= 1'b1;
                left_q         <= start_fin ? 5'd1 : 5'(udp_sram_pkg::LINE_BEATS);
            end else if (xfer) begin
                udp_tx_sof_o <= 1'b0;
                udp_tx_eof_o <= (left_q == 5'd1);
                if (left_q == 5'd0) begin
                    // eof word has gone out
                    udp_tx_valid_o <= 1'b0;
                    udp_tx_eof_o   <= 1'b0;
                end else begin
                    left_q <= left_q - 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cnna_finish_i) begin
            fin_cycles_q <= cnna_cycles_i;
        end
        if (start_fin || line_take_o) begin
            udp_tx_data_o      <= start_fin ? udp_sram_pkg::MAGIC_FINISH
                                            : udp_sram_pkg::MAGIC_WRITE;
            udp_tx_src_port_o  <= this_port_i;
            udp_tx_dest_port_o <= partner_port_i;
            udp_tx_dest_addr_o <= partner_addr_i;
            if (start_fin) begin
                shift_q[$bits(shift_q)-1 -: $bits(shift_top)] <= fin_cycles_q;
            end else begin
                shift_q <= line_i;
            end
        end else if (xfer && left_q != 5'd0) begin
            // slices leave most significant first
            udp_tx_data_o <= shift_top;
            shift_q       <= shift_q << $bits(shift_top);
        end
    end

    a_marks_valid: assert property (
        @(posedge clk_i) disable iff (reset_n_i)
        (udp_tx_sof_o || udp_tx_eof_o) |-> udp_tx_valid_o
    ) else $error("sof or eof without valid");

endmodule

`default_nettype wire

// ==== logic/udp_sram_bridge.sv ====
// udp to sram command bridge top level
// ties the decode, sram access and tx framing stages together
`timescale 1ns/10ps
`default_nettype none

module udp_sram_bridge (
    input  wire                       clk_i,
    input  wire                       reset_n_i,
    input  udp_sram_pkg::udp_word_t   udp_rx_data_i,
    input  wire                       udp_rx_valid_i,
    input  wire                       udp_rx_sof_i,
    input  wire                       udp_rx_eof_i,
    input  udp_sram_pkg::udp_port_t   udp_rx_src_port_i,
    input  udp_sram_pkg::udp_port_t   udp_rx_dest_port_i,
    input  udp_sram_pkg::ip_addr_t    udp_rx_src_addr_i,
    output udp_sram_pkg::udp_word_t   udp_tx_data_o,
    output logic                      udp_tx_valid_o,
    output logic                      udp_tx_sof_o,
    output logic                      udp_tx_eof_o,
    output udp_sram_pkg::udp_port_t   udp_tx_src_port_o,
    output udp_sram_pkg::udp_port_t   udp_tx_dest_port_o,
    output udp_sram_pkg::ip_addr_t    udp_tx_dest_addr_o,
    input  wire                       udp_tx_ready_i,
    input  udp_sram_pkg::sram_line_t  mem_rdata_i,
    output udp_sram_pkg::sram_wdata_t mem_wdata_o,
    output logic                      mem_wr_en_o,
    output logic                      mem_rd_en_o,
    output udp_sram_pkg::sram_addr_t  mem_addr_o,
    output logic                      cnna_start_o,
    input  wire                       cnna_finish_i,
    input  udp_sram_pkg::udp_word_t   cnna_cycles_i
);

    udp_sram_pkg::sram_line_t line;
    logic                     line_valid;
    logic                     line_take;
    udp_sram_pkg::udp_port_t  this_port;
    udp_sram_pkg::udp_port_t  partner_port;
    udp_sram_pkg::ip_addr_t   partner_addr;

    udp_cmd_if cmd_if ();

    udp_cmd_decode decode_i (
        .clk_i              (clk_i),
        .reset_n_i          (reset_n_i),
        .udp_rx_data_i      (udp_rx_data_i),
        .udp_rx_valid_i     (udp_rx_valid_i),
        .udp_rx_sof_i       (udp_rx_sof_i),
        .udp_rx_eof_i       (udp_rx_eof_i),
        .udp_rx_src_port_i  (udp_rx_src_port_i),
        .udp_rx_dest_port_i (udp_rx_dest_port_i),
        .udp_rx_src_addr_i  (udp_rx_src_addr_i),
        .cnna_start_o       (cnna_start_o),
        .this_port_o        (this_port),
        .partner_port_o     (partner_port),
        .partner_addr_o     (partner_addr),
        .cmd                (cmd_if.decoder)
    );

    sram_access access_i (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .mem_rdata_i  (mem_rdata_i),
        .line_take_i  (line_take),
        .mem_wdata_o  (mem_wdata_o),
        .mem_wr_en_o  (mem_wr_en_o),
        .mem_rd_en_o  (mem_rd_en_o),
        .mem_addr_o   (mem_addr_o),
        .line_o       (line),
        .line_valid_o (line_valid),
        .cmd          (cmd_if.executor)
    );

    udp_tx_framer framer_i (
        .clk_i              (clk_i),
        .reset_n_i          (reset_n_i),
        .line_i             (line),
        .line_valid_i       (line_valid),
        .cnna_finish_i      (cnna_finish_i),
        .cnna_cycles_i      (cnna_cycles_i),
        .this_port_i        (this_port),
        .partner_port_i     (partner_port),
        .partner_addr_i     (partner_addr),
        .udp_tx_ready_i     (udp_tx_ready_i),
        .line_take_o        (line_take),
        .udp_tx_data_o      (udp_tx_data_o),
        .udp_tx_valid_o     (udp_tx_valid_o),
        .udp_tx_sof_o       (udp_tx_sof_o),
        .udp_tx_eof_o       (udp_tx_eof_o),
        .udp_tx_src_port_o  (udp_tx_src_port_o),
        .udp_tx_dest_port_o (udp_tx_dest_port_o),
        .udp_tx_dest_addr_o (udp_tx_dest_addr_o)
    );

endmodule

`default_nettype wire

// ==== tests/udp_sram_checks.svh ====
// compare tasks and error counters for the udp sram bridge testbench
// one task per kind of result, each prints a FAIL line on mismatch
`ifndef UDP_SRAM_CHECKS_SVH
`define UDP_SRAM_CHECKS_SVH

int err_count = 0;
int check_count = 0;

task automatic check_word(input udp_sram_pkg::udp_word_t got,
                          input udp_sram_pkg::udp_word_t exp, input string msg);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
endtask

task automatic check_wdata(input udp_sram_pkg::sram_wdata_t got,
                           input udp_sram_pkg::sram_wdata_t exp, input string msg);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
endtask

task automatic check_addr(input udp_sram_pkg::sram_addr_t got,
                          input udp_sram_pkg::sram_addr_t exp, input string msg);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
endtask

task automatic check_port(input udp_sram_pkg::udp_port_t got,
                          input udp_sram_pkg::udp_port_t exp, input string msg);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
endtask

`endif

// ==== tests/udp_sram_tb.sv ====
// testbench for the udp to sram command bridge
// plays operations from the stimulus file, models the sram
// and collects outbound frames for comparison
`timescale 1ns/10ps
`default_nettype none

module udp_sram_tb;

    localparam udp_sram_pkg::udp_port_t SENDER_PORT = 16'h4321;
    localparam udp_sram_pkg::ip_addr_t  SENDER_ADDR = 32'h0a000002;

    logic                      clk_i;
    logic                      reset_n_i;
    udp_sram_pkg::udp_word_t   udp_rx_data_i;
    logic                      udp_rx_valid_i;
    logic                      udp_rx_sof_i;
    logic                      udp_rx_eof_i;
    udp_sram_pkg::udp_port_t   udp_rx_src_port_i;
    udp_sram_pkg::udp_port_t   udp_rx_dest_port_i;
    udp_sram_pkg::ip_addr_t    udp_rx_src_addr_i;
    udp_sram_pkg::udp_word_t   udp_tx_data_o;
    logic                      udp_tx_valid_o;
    logic                      udp_tx_sof_o;
    logic                      udp_tx_eof_o;
    udp_sram_pkg::udp_port_t   udp_tx_src_port_o;
    udp_sram_pkg::udp_port_t   udp_tx_dest_port_o;
    udp_sram_pkg::ip_addr_t    udp_tx_dest_addr_o;
    logic                      udp_tx_ready_i;
    udp_sram_pkg::sram_line_t  mem_rdata_i;
    udp_sram_pkg::sram_wdata_t mem_wdata_o;
    logic                      mem_wr_en_o;
    logic                      mem_rd_en_o;
    udp_sram_pkg::sram_addr_t  mem_addr_o;
    logic                      cnna_start_o;
    logic                      cnna_finish_i;
    udp_sram_pkg::udp_word_t   cnna_cycles_i;

    `include "udp_sram_checks.svh"

    // sram model image and the image expected from the stimulus
    udp_sram_pkg::sram_wdata_t mem [0:255];
    udp_sram_pkg::sram_wdata_t exp_mem [0:255];

    udp_sram_pkg::udp_word_t   frame_buf [0:7];
    udp_sram_pkg::udp_word_t   rx_q [$];
    logic                      rx_sof_q [$];
    logic                      rx_eof_q [$];
    udp_sram_pkg::udp_word_t   exp_q [$];
    logic                      exp_sof_q [$];
    logic                      exp_eof_q [$];
    udp_sram_pkg::udp_port_t   rx_src_port;
    udp_sram_pkg::udp_port_t   rx_dest_port;
    udp_sram_pkg::ip_addr_t    rx_dest_addr;
    udp_sram_pkg::sram_wdata_t wr_data;
    udp_sram_pkg::sram_addr_t  wr_addr;
    int                        wr_count;
    int                        rd_count;
    int                        start_count;
    int                        frames_done;
    int                        wd_limit;
    logic                      random_ready;
    integer                    seed;

    udp_sram_bridge dut_i (.*);

    function automatic udp_sram_pkg::sram_wdata_t fill_entry(input udp_sram_pkg::sram_addr_t a);
        return {4{~a, a, a ^ 8'h3c, 8'hc3}};
    endfunction

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    // sram model, collector and strobe counters
    initial begin
        udp_sram_pkg::sram_addr_t ra;
        int                       rd_age;
        ra = '0;
        rd_age = 0;
        forever begin
            @(posedge clk_i);
            // edges seen since the last read enable
            if (rd_age > 0 && rd_age < udp_sram_pkg::READ_LATENCY) begin
                rd_age++;
            end else begin
                rd_age = 0;
            end
            if (!reset_n_i) begin
                if (mem_wr_en_o) begin
                    wr_count++;
                    wr_data = mem_wdata_o;
                    wr_addr = mem_addr_o;
                    mem[mem_addr_o] = mem_wdata_o;
                end
                if (mem_rd_en_o) begin
                    rd_count++;
                    ra = mem_addr_o;
                    rd_age = 1;
                end
                if (cnna_start_o) begin
                    start_count++;
                end
                if (udp_tx_valid_o && udp_tx_ready_i) begin
                    rx_q.push_back(udp_tx_data_o);
                    rx_sof_q.push_back(udp_tx_sof_o);
                    rx_eof_q.push_back(udp_tx_eof_o);
                    if (udp_tx_sof_o) begin
                        rx_src_port  = udp_tx_src_port_o;
                        rx_dest_port = udp_tx_dest_port_o;
                        rx_dest_addr = udp_tx_dest_addr_o;
                    end
                    if (udp_tx_eof_o) begin
                        frames_done++;
                    end
                end
            end
            #1;
            // line is valid only for the edge READ_LATENCY cycles after the enable
            if (rd_age == udp_sram_pkg::READ_LATENCY - 1) begin
                mem_rdata_i = {mem[ra], mem[ra + 8'd1], mem[ra + 8'd2], mem[ra + 8'd3]};
            end else begin
                mem_rdata_i = 'x;
            end
        end
    end

    initial begin
        integer rnd;
        forever begin
            @(posedge clk_i);
            #1;
            if (random_ready) begin
                rnd = $random(seed);
                udp_tx_ready_i = rnd[0];
            end else begin
                udp_tx_ready_i = 1'b1;
            end
        end
    end

    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge clk_i);
        $display("timeout after %0d cycles, the run did not complete", wd_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    // wait for a counter to reach n, kind selects the counter
    task automatic wait_for(input string kind, input int n, input int limit);
        int t;
        int cur;
        t = 0;
        cur = 0;
        while (t < limit) begin
            if (kind == "write") cur = wr_count;
            else if (kind == "start") cur = start_count;
            else if (kind == "frame") cur = frames_done;
            else cur = rx_q.size();
            if (cur >= n) break;
            step();
            t++;
        end
        if (cur < n) begin
            err_count++;
            $display("no %s event seen within %0d cycles", kind, limit);
        end
    endtask

    task automatic send_frame(input udp_sram_pkg::udp_port_t port, input int n);
        for (int i = 0; i < n; i++) begin
            udp_rx_data_i      = frame_buf[i];
            udp_rx_valid_i     = 1'b1;
            udp_rx_sof_i       = (i == 0);
            udp_rx_eof_i       = (i == n - 1);
            udp_rx_dest_port_i = port;
            step();
        end
        udp_rx_valid_i = 1'b0;
        udp_rx_sof_i   = 1'b0;
        udp_rx_eof_i   = 1'b0;
    endtask

    task automatic clear_counts();
        wr_count    = 0;
        rd_count    = 0;
        start_count = 0;
        frames_done = 0;
        rx_q.delete();
        rx_sof_q.delete();
        rx_eof_q.delete();
        exp_q.delete();
        exp_sof_q.delete();
        exp_eof_q.delete();
    endtask

    task automatic expect_line(input udp_sram_pkg::sram_addr_t p);
        udp_sram_pkg::sram_line_t ln;
        ln = {exp_mem[p], exp_mem[p + 8'd1], exp_mem[p + 8'd2], exp_mem[p + 8'd3]};
        exp_q.push_back(udp_sram_pkg::MAGIC_WRITE);
        exp_sof_q.push_back(1'b1);
        exp_eof_q.push_back(1'b0);
        for (int k = 0; k < udp_sram_pkg::LINE_BEATS; k++) begin
            exp_q.push_back(ln[511 - 32 * k -: 32]);
            exp_sof_q.push_back(1'b0);
            exp_eof_q.push_back(k == udp_sram_pkg::LINE_BEATS - 1);
        end
    endtask

    task automatic expect_finish(input udp_sram_pkg::udp_word_t cyc);
        exp_q.push_back(udp_sram_pkg::MAGIC_FINISH);
        exp_sof_q.push_back(1'b1);
        exp_eof_q.push_back(1'b0);
        exp_q.push_back(cyc);
        exp_sof_q.push_back(1'b0);
        exp_eof_q.push_back(1'b1);
    endtask

    task automatic compare_frames();
        check_word(rx_q.size(), exp_q.size(), "frame word count");
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check_word(rx_q[i], exp_q[i], $sformatf("tx word %0d", i));
            check_word(32'(rx_sof_q[i]), 32'(exp_sof_q[i]), $sformatf("sof on word %0d", i));
            check_word(32'(rx_eof_q[i]), 32'(exp_eof_q[i]), $sformatf("eof on word %0d", i));
        end
        check_port(rx_src_port, udp_sram_pkg::LISTEN_PORT, "tx source port");
        check_port(rx_dest_port, SENDER_PORT, "tx destination port");
        check_word(rx_dest_addr, SENDER_ADDR, "tx destination address");
    endtask

    task automatic pulse_finish(input udp_sram_pkg::udp_word_t cyc);
        cnna_finish_i = 1'b1;
        cnna_cycles_i = cyc;
        step();
        cnna_finish_i = 1'b0;
        // later values must not reach the report
        cnna_cycles_i = ~cyc;
    endtask

    // one operation per stimulus line
    task automatic play_stimulus();
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] a [0:5];
        fd = $fopen("tests/udp_sram_stim.txt", "r");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n <= 1 || line.substr(0, 0) == "#") continue;
            for (int i = 0; i < 6; i++) a[i] = '0;
            n = $sscanf(line, "%s %h %h %h %h %h %h", op, a[0], a[1], a[2], a[3], a[4], a[5]);
            clear_counts();
            if (op == "P") begin
                random_ready = a[0][0];
            end else if (op == "W") begin
                frame_buf[0] = udp_sram_pkg::MAGIC_WRITE;
                for (int i = 0; i < 4; i++) frame_buf[i + 1] = a[i + 1];
                frame_buf[5] = {24'h0, a[0][7:0]};
                send_frame(udp_sram_pkg::LISTEN_PORT, 6);
                wait_for("write", 1, 20);
                repeat (3) step();
                check_word(wr_count, 1, "write strobe count");
                check_wdata(wr_data, {a[1], a[2], a[3], a[4]}, "write word");
                check_addr(wr_addr, a[0][7:0], "write address");
                exp_mem[a[0][7:0]] = {a[1], a[2], a[3], a[4]};
            end else if (op == "I") begin
                for (int i = 0; i < 4; i++) frame_buf[i] = a[i + 2];
                send_frame(a[0][15:0], a[1]);
                repeat (8) step();
                check_word(wr_count, 0, "write strobes for ignored frame");
                check_word(rd_count, 0, "read strobes for ignored frame");
                check_word(start_count, 0, "start pulses for ignored frame");
            end else if (op == "S") begin
                frame_buf[0] = udp_sram_pkg::MAGIC_START;
                send_frame(udp_sram_pkg::LISTEN_PORT, 1);
                wait_for("start", 1, 20);
                repeat (4) step();
                check_word(start_count, 1, "start pulse count");
            end else if (op == "R") begin
                frame_buf[0] = udp_sram_pkg::MAGIC_READ;
                send_frame(udp_sram_pkg::LISTEN_PORT, 1);
                expect_line(a[0][7:0]);
                wait_for("frame", 1, 150);
                repeat (3) step();
                compare_frames();
                check_word(rd_count, 1, "read strobe count");
            end else if (op == "F") begin
                pulse_finish(a[0]);
                expect_finish(a[0]);
                wait_for("frame", 1, 50);
                repeat (3) step();
                compare_frames();
            end else if (op == "B") begin
                frame_buf[0] = udp_sram_pkg::MAGIC_READ;
                send_frame(udp_sram_pkg::LISTEN_PORT, 1);
                wait_for("word", 1, 50);
                pulse_finish(a[1]);
                expect_line(a[0][7:0]);
                expect_finish(a[1]);
                wait_for("frame", 2, 200);
                repeat (3) step();
                compare_frames();
                check_word(rd_count, 1, "read strobe count");
            end else begin
                err_count++;
                $display("unknown operation in stimulus line: %s", line);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int        fd;
        int        n;
        int        op_lines;
        string     line;
        clk_i              = 1'b0;
        reset_n_i          = 1'b1;
        udp_rx_data_i      = '0;
        udp_rx_valid_i     = 1'b0;
        udp_rx_sof_i       = 1'b0;
        udp_rx_eof_i       = 1'b0;
        udp_rx_src_port_i  = SENDER_PORT;
        udp_rx_dest_port_i = '0;
        udp_rx_src_addr_i  = SENDER_ADDR;
        udp_tx_ready_i     = 1'b1;
        mem_rdata_i        = '0;
        cnna_finish_i      = 1'b0;
        cnna_cycles_i      = '0;
        random_ready       = 1'b0;
        seed               = 32'he16eff5c;
        wd_limit           = 0;
        clear_counts();
        for (int i = 0; i < 256; i++) begin
            mem[i]     = fill_entry(8'(i));
            exp_mem[i] = fill_entry(8'(i));
        end

        op_lines = 0;
        fd = $fopen("tests/udp_sram_stim.txt", "r");
        if (fd == 0) begin
            err_count++;
            $display("could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.substr(0, 0) != "#") op_lines++;
            end
            $fclose(fd);
            wd_limit = 200 * op_lines + 100;

            repeat (5) @(posedge clk_i);
            #1;
            reset_n_i = 1'b0;
            repeat (3) step();

            play_stimulus();
        end

        repeat (5) step();
        $display("checks run %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/udp_sram_stim.txt ====
# op and hex operands: W addr d0 d1 d2 d3 | I port nwords w0..w3 | R ptr
# S | F cycles | B ptr cycles (read with finish during frame) | P ready_random
P 0
W 00 11111111 22222222 33333333 44444444
W 01 55555555 66666666 77777777 88888888
W 02 99999999 aaaaaaaa bbbbbbbb cccccccc
W 03 dddddddd eeeeeeee ffffffff 01234567
W 04 89abcdef fedcba98 76543210 0f1e2d3c
R 0
R 1
I 0709 1 722acce7
I 0708 1 12345678
I 0708 4 722acce7 aaaa0001 bbbb0002 cccc0003
S
F 000004d2
P 1
W 05 a5a5a5a5 5a5a5a5a c3c3c3c3 3c3c3c3c
R 0
R 1
R 2
B 3 0000beef
P 0
R 4
F 00c0ffee

// ==== src.f ====
+incdir+tests
logic/udp_sram_pkg.sv
logic/udp_cmd_if.sv
logic/udp_cmd_decode.sv
logic/sram_access.sv
logic/udp_tx_framer.sv
logic/udp_sram_bridge.sv
tests/udp_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, fail if the log reports failure
rm -f sim.log
verilator --binary --timing --top-module udp_sram_tb -Mdir obj_dir -f src.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vudp_sram_tb > sim.log 2>&1
cat sim.log
test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
